/* verilog/fixed_pkg.sv */
package fixed_pkg;

    // Q8.24 word
    localparam int WORD_WIDTH = 32;
    localparam int FRAC_BITS = 24;

    typedef logic [WORD_WIDTH-1:0] fp;
    typedef logic signed [WORD_WIDTH-1:0] sfp;

    localparam fp FP_ONE = fp'(1) << FRAC_BITS;
    localparam fp FP_MAX = '1;

    // unsigned product, fraction bits dropped
    function automatic fp fp_mul(input fp a, input fp b);
        logic [2*WORD_WIDTH-1:0] prod;
        prod = a * b;
        return prod[FRAC_BITS +: WORD_WIDTH];
    endfunction

    // signed product; operands are one bit wider so an unsigned word keeps its value
    // dropping the low bits of a two's complement product rounds toward minus infinity
    function automatic sfp sfp_mul(input logic signed [WORD_WIDTH:0] a,
                                   input logic signed [WORD_WIDTH:0] b);
        logic signed [2*WORD_WIDTH+1:0] prod;
        prod = a * b;
        return prod[FRAC_BITS +: WORD_WIDTH];
    endfunction

endpackage

/* verilog/vector_pkg.sv */
package vector_pkg;

    localparam int N_COMP = 3;

    // leading-one range that is normalized, and where the one lands
    localparam int LEAD_HI = 31;
    localparam int LEAD_LO = 10;
    localparam int WIN_BIT = 23;

    // floor(2^24 * 2^(-e/2)) for e = -13 .. 8
    localparam fixed_pkg::fp HALF_POW_TABLE [LEAD_HI - LEAD_LO + 1] = '{
        32'h5A827999, 32'h40000000, 32'h2D413CCC, 32'h20000000,
        32'h16A09E66, 32'h10000000, 32'h0B504F33, 32'h08000000,
        32'h05A82799, 32'h04000000, 32'h02D413CC, 32'h02000000,
        32'h016A09E6, 32'h01000000, 32'h00B504F3, 32'h00800000,
        32'h005A8279, 32'h00400000, 32'h002D413C, 32'h00200000,
        32'h0016A09E, 32'h00100000
    };

    // bit-by-bit integer square root
    function automatic logic [63:0] isqrt(input logic [63:0] v);
        logic [63:0] rem;
        logic [63:0] root;
        logic [63:0] probe;
        rem = v;
        root = '0;
        probe = 64'h1 << 62;
        for (int i = 0; i < 32; i++) begin
            if (rem >= root + probe) begin
                rem = rem - (root + probe);
                root = (root >> 1) + probe;
            end else begin
                root = root >> 1;
            end
            probe = probe >> 2;
        end
        return root;
    endfunction

    // entry a stands for a * 2^-addr_bits, so 2^42 / isqrt(a << (36 - addr_bits)) is its
    // inverse root in Q8.24
    function automatic fixed_pkg::fp rsqrt_entry(input int unsigned a,
                                                 input int unsigned addr_bits);
        logic [63:0] root;
        logic [63:0] quot;
        if (a < (32'd1 << (addr_bits - 1))) begin
            return fixed_pkg::FP_MAX;
        end
        root = isqrt(64'(a) << (36 - addr_bits));
        quot = (64'd1 << 42) / root;
        if (quot > 64'(fixed_pkg::FP_MAX)) begin
            return fixed_pkg::FP_MAX;
        end
        return quot[fixed_pkg::WORD_WIDTH-1:0];
    endfunction

    function automatic fixed_pkg::fp half_pow_scale(input int e);
        return HALF_POW_TABLE[e - (LEAD_LO - WIN_BIT)];
    endfunction

endpackage

/* verilog/vec_sum_squares.sv */
module vec_sum_squares #(
    parameter int COMPS = vector_pkg::N_COMP
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  fixed_pkg::sfp    in_vec [COMPS],
    output logic             sq_valid,
    output fixed_pkg::fp     sq_sum,
    output fixed_pkg::sfp    sq_vec [COMPS]
);

    localparam int W = fixed_pkg::WORD_WIDTH;
    localparam int ACC_W = W + $clog2(COMPS + 1);
    // a magnitude with any bit at or above this one squares to 256 or more
    localparam int SQ_LIMIT_BIT = fixed_pkg::FRAC_BITS + (W - fixed_pkg::FRAC_BITS) / 2;

    logic [ACC_W-1:0] acc;
    fixed_pkg::fp     mag;
    logic             ovf;
    fixed_pkg::fp     sum_next;

    always_comb begin
        acc = '0;
        mag = '0;
        ovf = 1'b0;
        for (int i = 0; i < COMPS; i++) begin
            mag = in_vec[i][W-1] ? fixed_pkg::fp'(-in_vec[i]) : fixed_pkg::fp'(in_vec[i]);
            ovf = ovf | (|(mag >> SQ_LIMIT_BIT));
            // square is below 2^32 whenever ovf stays low, so the unsigned view is exact
            acc = acc + ACC_W'(fixed_pkg::fp'(fixed_pkg::sfp_mul(in_vec[i], in_vec[i])));
        end
        if (ovf || acc > ACC_W'(fixed_pkg::FP_MAX)) begin
            sum_next = fixed_pkg::FP_MAX;
        end else begin
            sum_next = acc[W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sq_valid <= 1'b0;
            sq_sum <= '0;
            for (int i = 0; i < COMPS; i++) begin
                sq_vec[i] <= '0;
            end
        end else begin
            sq_valid <= in_valid;
            if (in_valid) begin
                sq_sum <= sum_next;
                sq_vec <= in_vec;
            end
        end
    end

endmodule

/* verilog/rsqrt_normalize.sv */
module rsqrt_normalize (
    input  logic          clk,
    input  logic          rst,
    input  logic          sq_valid,
    input  fixed_pkg::fp  sq_sum,
    output logic          nm_valid,
    output fixed_pkg::fp  nm_frac,
    output fixed_pkg::fp  nm_scale,
    output logic          nm_zero
);

    int           lead_pos;
    logic         found;
    fixed_pkg::fp frac_next;
    fixed_pkg::fp scale_next;

    // priority encoder, highest set bit in the handled range wins
    always_comb begin
        lead_pos = vector_pkg::LEAD_LO;
        found = 1'b0;
        for (int b = vector_pkg::LEAD_LO; b <= vector_pkg::LEAD_HI; b++) begin
            if (sq_sum[b]) begin
                lead_pos = b;
                found = 1'b1;
            end
        end
    end

    // move the leading one to the window bit, sum ends up in [0.5, 1)
    always_comb begin
        if (!found) begin
            // degenerate sum, park at 0.5 so the table read stays defined
            frac_next = fixed_pkg::FP_ONE >> 1;
            scale_next = fixed_pkg::FP_ONE;
        end else begin
            if (lead_pos >= vector_pkg::WIN_BIT) begin
                frac_next = sq_sum >> (lead_pos - vector_pkg::WIN_BIT);
            end else begin
                frac_next = sq_sum << (vector_pkg::WIN_BIT - lead_pos);
            end
            scale_next = vector_pkg::half_pow_scale(lead_pos - vector_pkg::WIN_BIT);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            nm_valid <= 1'b0;
            nm_frac <= '0;
            nm_scale <= '0;
            nm_zero <= 1'b0;
        end else begin
            nm_valid <= sq_valid;
            if (sq_valid) begin
                nm_frac <= frac_next;
                nm_scale <= scale_next;
                nm_zero <= !found;
            end
        end
    end

endmodule

/* verilog/rsqrt_lookup.sv */
module rsqrt_lookup #(
    parameter int ADDR_BITS = 12
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          nm_valid,
    input  fixed_pkg::fp  nm_frac,
    input  fixed_pkg::fp  nm_scale,
    input  logic          nm_zero,
    output logic          inv_valid,
    output fixed_pkg::fp  inv_norm,
    output logic          inv_zero
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    fixed_pkg::fp         rom [DEPTH];
    logic [ADDR_BITS-1:0] rd_addr;

    // read stage
    logic         rd_valid;
    fixed_pkg::fp rd_data;
    fixed_pkg::fp rd_scale;
    logic         rd_zero;

    // table contents are constants worked out at elaboration
    for (genvar i = 0; i < DEPTH; i++) begin : g_rom
        localparam fixed_pkg::fp ENTRY = vector_pkg::rsqrt_entry(i, ADDR_BITS);
        assign rom[i] = ENTRY;
    end

    // top bits of the window, starting at the leading one
    assign rd_addr = nm_frac[vector_pkg::WIN_BIT -: ADDR_BITS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid <= 1'b0;
            rd_data <= '0;
            rd_scale <= '0;
            rd_zero <= 1'b0;
        end else begin
            rd_valid <= nm_valid;
            if (nm_valid) begin
                rd_data <= rom[rd_addr];
                rd_scale <= nm_scale;
                rd_zero <= nm_zero;
            end
        end
    end

    // undo the normalization shift
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inv_valid <= 1'b0;
            inv_norm <= '0;
            inv_zero <= 1'b0;
        end else begin
            inv_valid <= rd_valid;
            if (rd_valid) begin
                inv_norm <= fixed_pkg::fp_mul(rd_data, rd_scale);
                inv_zero <= rd_zero;
            end
        end
    end

endmodule

/* verilog/vec_scale.sv */
module vec_scale #(
    parameter int COMPS = vector_pkg::N_COMP
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           sq_valid,
    input  fixed_pkg::sfp  sq_vec [COMPS],
    input  logic           inv_valid,
    input  fixed_pkg::fp   inv_norm,
    input  logic           inv_zero,
    output logic           out_valid,
    output fixed_pkg::sfp  out_vec [COMPS]
);

    // matches normalize plus the two lookup stages
    localparam int DELAY = 3;

    fixed_pkg::sfp    dly [DELAY][COMPS];
    logic [DELAY-2:0] dly_valid;

    // inverse norm can reach 128.0, so it goes in with a zero sign bit
    logic signed [fixed_pkg::WORD_WIDTH:0] norm_ext;

    assign norm_ext = $signed({1'b0, inv_norm});

    // each tap loads only behind a valid entry
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dly_valid <= '0;
            for (int s = 0; s < DELAY; s++) begin
                for (int i = 0; i < COMPS; i++) begin
                    dly[s][i] <= '0;
                end
            end
        end else begin
            dly_valid[0] <= sq_valid;
            for (int s = 1; s < DELAY - 1; s++) begin
                dly_valid[s] <= dly_valid[s-1];
            end
            if (sq_valid) begin
                dly[0] <= sq_vec;
            end
            for (int s = 1; s < DELAY; s++) begin
                if (dly_valid[s-1]) begin
                    dly[s] <= dly[s-1];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < COMPS; i++) begin
                out_vec[i] <= '0;
            end
        end else begin
            out_valid <= inv_valid;
            if (inv_valid) begin
                for (int i = 0; i < COMPS; i++) begin
                    out_vec[i] <= inv_zero ? '0 : fixed_pkg::sfp_mul(dly[DELAY-1][i], norm_ext);
                end
            end
        end
    end

endmodule

/* verilog/vec_normalizer.sv */
module vec_normalizer #(
    parameter int COMPS = vector_pkg::N_COMP,
    parameter int ADDR_BITS = 12
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  fixed_pkg::sfp  in_vec [COMPS],
    output logic           out_valid,
    output fixed_pkg::sfp  out_vec [COMPS]
);

    // stage 1
    logic          sq_valid;
    fixed_pkg::fp  sq_sum;
    fixed_pkg::sfp sq_vec [COMPS];

    // stage 2
    logic          nm_valid;
    fixed_pkg::fp  nm_frac;
    fixed_pkg::fp  nm_scale;
    logic          nm_zero;

    // stages 3 and 4
    logic          inv_valid;
    fixed_pkg::fp  inv_norm;
    logic          inv_zero;

    vec_sum_squares #(
        .COMPS(COMPS)
    ) vec_sum_squares_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_vec(in_vec),
        .sq_valid(sq_valid),
        .sq_sum(sq_sum),
        .sq_vec(sq_vec)
    );

    rsqrt_normalize rsqrt_normalize_i (
        .clk(clk),
        .rst(rst),
        .sq_valid(sq_valid),
        .sq_sum(sq_sum),
        .nm_valid(nm_valid),
        .nm_frac(nm_frac),
        .nm_scale(nm_scale),
        .nm_zero(nm_zero)
    );

    rsqrt_lookup #(
        .ADDR_BITS(ADDR_BITS)
    ) rsqrt_lookup_i (
        .clk(clk),
        .rst(rst),
        .nm_valid(nm_valid),
        .nm_frac(nm_frac),
        .nm_scale(nm_scale),
        .nm_zero(nm_zero),
        .inv_valid(inv_valid),
        .inv_norm(inv_norm),
        .inv_zero(inv_zero)
    );

    // components come straight from stage 1 and wait inside for the norm
    vec_scale #(
        .COMPS(COMPS)
    ) vec_scale_i (
        .clk(clk),
        .rst(rst),
        .sq_valid(sq_valid),
        .sq_vec(sq_vec),
        .inv_valid(inv_valid),
        .inv_norm(inv_norm),
        .inv_zero(inv_zero),
        .out_valid(out_valid),
        .out_vec(out_vec)
    );

endmodule

/* bench/vec_normalizer_tb.sv */
module vec_normalizer_tb;

    localparam int COMPS = vector_pkg::N_COMP;
    localparam int ADDR_BITS = 12;
    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY = 5;
    localparam int N_DIRECTED = 15;
    localparam int N_RANDOM = 500;
    localparam int MAX_GAP = 2;
    // every vector takes at most one cycle plus its gap
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (N_DIRECTED + N_RANDOM) * (MAX_GAP + 1) + 100;

    // Q8.24 format and normalization window
    localparam int FRAC = 24;
    localparam int MIN_LEAD = 10;
    localparam int WIN = 23;
    localparam longint unsigned WORD_MAX = 64'hFFFF_FFFF;

    logic          clk;
    logic          rst;
    logic          in_valid;
    fixed_pkg::sfp in_vec [COMPS];
    logic          out_valid;
    fixed_pkg::sfp out_vec [COMPS];

    fixed_pkg::sfp exp_q [$];
    int            cyc_q [$];
    int            cyc = 0;
    int            n_sent = 0;
    int            n_checked = 0;
    integer        seed;

    vec_normalizer #(
        .COMPS(COMPS),
        .ADDR_BITS(ADDR_BITS)
    ) vec_normalizer_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_vec(in_vec),
        .out_valid(out_valid),
        .out_vec(out_vec)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (got !== want) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, want, got);
            fail_run("value mismatch");
        end
    endtask

    // exact floor square root, starting from a real estimate
    function automatic longint unsigned int_sqrt(input longint unsigned x);
        longint unsigned r;
        r = $rtoi($sqrt(x));
        while (r * r > x) r--;
        while ((r + 1) * (r + 1) <= x) r++;
        return r;
    endfunction

    // whole chain from the format rules
    function automatic void model_normalize(input fixed_pkg::sfp v [COMPS],
                                            output fixed_pkg::sfp r [COMPS]);
        longint unsigned sq;
        longint unsigned sum;
        longint unsigned frac;
        longint unsigned addr;
        longint unsigned entry;
        longint unsigned scale;
        longint unsigned inv;
        longint          prod;
        longint          shifted;
        real             sc;
        int              lead;
        int              e;
        sum = 0;
        for (int i = 0; i < COMPS; i++) begin
            sq = longint'(v[i]) * longint'(v[i]);
            sum = sum + (sq >> FRAC);
        end
        if (sum > WORD_MAX) sum = WORD_MAX;
        lead = -1;
        for (int b = 0; b < 32; b++) begin
            if (sum[b]) lead = b;
        end
        if (lead < MIN_LEAD) begin
            for (int i = 0; i < COMPS; i++) r[i] = '0;
            return;
        end
        e = lead - WIN;
        frac = (e >= 0) ? (sum >> e) : (sum << -e);
        addr = frac >> (WIN + 1 - ADDR_BITS);
        entry = (64'd1 << 42) / int_sqrt(addr << 24);
        if (entry > WORD_MAX) entry = WORD_MAX;
        sc = $floor(16777216.0 * (2.0 ** (-e / 2.0)));
        scale = $rtoi(sc);
        inv = ((entry * scale) >> FRAC) & WORD_MAX;
        for (int i = 0; i < COMPS; i++) begin
            prod = longint'(v[i]) * $signed(inv);
            shifted = prod >>> FRAC;
            r[i] = shifted[31:0];
        end
    endfunction

    function automatic fixed_pkg::sfp to_fix(input real x);
        return $rtoi(x * 16777216.0);
    endfunction

    task automatic send_vec(input real x, input real y, input real z);
        @(posedge clk);
        in_valid <= 1'b1;
        in_vec[0] <= to_fix(x);
        in_vec[1] <= to_fix(y);
        in_vec[2] <= to_fix(z);
        n_sent++;
    endtask

    // components of one vector share a rough magnitude
    task automatic send_random();
        int base;
        base = $unsigned($random(seed)) % 28;
        @(posedge clk);
        in_valid <= 1'b1;
        for (int i = 0; i < COMPS; i++) begin
            in_vec[i] <= $random(seed) >>> (base + $unsigned($random(seed)) % 4);
        end
        n_sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // expected values queued in input order, popped on out_valid
    always @(posedge clk) begin : scoreboard
        fixed_pkg::sfp want [COMPS];
        int            in_cyc;
        if (in_valid) begin
            model_normalize(in_vec, want);
            for (int i = 0; i < COMPS; i++) exp_q.push_back(want[i]);
            cyc_q.push_back(cyc);
        end
        if (out_valid) begin
            if (cyc_q.size() == 0) begin
                fail_run("out_valid is high with no vector in flight");
            end else begin
                in_cyc = cyc_q.pop_front();
                if (cyc - in_cyc != LATENCY) begin
                    fail_run($sformatf("output came %0d cycles after its input, not %0d",
                                       cyc - in_cyc, LATENCY));
                end
                for (int i = 0; i < COMPS; i++) begin
                    check_value($sformatf("out_vec[%0d]", i), exp_q.pop_front(), out_vec[i]);
                end
                n_checked++;
            end
        end
        cyc++;
    end

    initial begin
        #(longint'(WATCHDOG_CYCLES) * PERIOD);
        fail_run("timeout, the outputs did not all arrive in time");
    end

    initial begin
        seed = 99235;
        rst = 1'b0;
        in_valid = 1'b0;
        for (int i = 0; i < COMPS; i++) in_vec[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        check_value("out_valid", 32'd0, 32'(out_valid));
        for (int i = 0; i < COMPS; i++) begin
            check_value($sformatf("out_vec[%0d]", i), 32'd0, out_vec[i]);
        end
        rst <= 1'b1;
        idle(6);

        // axis-aligned, odd and even shifts
        send_vec(1.0, 0.0, 0.0);
        idle(2);
        send_vec(2.0, 0.0, 0.0);
        send_vec(0.0, -0.5, 0.0);
        send_vec(0.0, 0.0, 3.0);
        send_vec(0.0, 0.0, -0.25);
        idle(3);
        send_vec(0.5, 0.5, 0.0);
        send_vec(0.6, 0.8, 0.0);
        idle(1);

        // zero and degenerate sums, then the smallest handled one
        send_vec(0.0, 0.0, 0.0);
        send_vec(0.00390625, 0.00390625, -0.00390625);
        send_vec(0.0078125, 0.0, 0.0);
        idle(4);

        // sums past the word saturate
        send_vec(16.0, 0.0, 0.0);
        send_vec(10.0, -10.0, 10.0);
        send_vec(-128.0, 0.0, 0.0);
        send_vec(-100.0, 50.0, 7.0);
        send_vec(15.9, 0.0, 0.0);
        idle(2);

        for (int n = 0; n < N_RANDOM; n++) begin
            send_random();
            idle($unsigned($random(seed)) % (MAX_GAP + 1));
        end
        idle(4);

        // last output is due well inside this drain
        repeat (LATENCY + 3) @(negedge clk);
        if (n_checked != n_sent) begin
            fail_run($sformatf("%0d vectors sent but %0d checked", n_sent, n_checked));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* vlog.f */
verilog/fixed_pkg.sv
verilog/vector_pkg.sv
verilog/vec_sum_squares.sv
verilog/rsqrt_normalize.sv
verilog/rsqrt_lookup.sv
verilog/vec_scale.sv
verilog/vec_normalizer.sv
bench/vec_normalizer_tb.sv

/* Bender.yml */
package:
  name: vec_normalizer

sources:
  - verilog/fixed_pkg.sv
  - verilog/vector_pkg.sv
  - verilog/vec_sum_squares.sv
  - verilog/rsqrt_normalize.sv
  - verilog/rsqrt_lookup.sv
  - verilog/vec_scale.sv
  - verilog/vec_normalizer.sv
  - target: test
    files:
      - bench/vec_normalizer_tb.sv
